/* src/io_config.svh */
`ifndef IO_CONFIG_SVH
`define IO_CONFIG_SVH

// data path and slot sizing
`define IO_WIDTH  16
`define NUM_SLOTS 4   // slot 0 plus three task slots

// one-hot io address bits, one register per bit
`define ADDR_PA_DATA    0   // gp port data, pins on read
`define ADDR_PA_DIR     1   // gp port direction, 1 is output
`define ADDR_LEDS       2   // led port
// bits 3 to 7 read zero
`define ADDR_XT1        8   // slot 1 execution token
`define ADDR_XT2        9   // slot 2 execution token
`define ADDR_XT3        10  // slot 3 execution token
`define ADDR_WARMBOOT   11  // write only
// bit 12 reads zero
`define ADDR_MISC       13  // misc out readback + misc in
`define ADDR_TASK_FETCH 14  // fetch own token, write kills slots
`define ADDR_SLOT_MASK  15  // read slot id, write next-access mask

`endif

/* src/io_bus_pkg.sv */
`include "io_config.svh"

// types for the processor io bus
package io_bus_pkg;

  // one io word, data or one-hot address
  typedef logic [`IO_WIDTH-1:0] io_word_t;

  // issuing slot number
  typedef logic [$clog2(`NUM_SLOTS)-1:0] slot_t;

  // request as seen one cycle after the processor drove it
  typedef struct packed {
    logic     rd;    // read strobe
    logic     wr;    // write strobe
    slot_t    slot;  // who issued it
    io_word_t addr;  // one-hot, zero when idle
    io_word_t data;  // write data
  } io_req_t;

endpackage

/* src/task_pkg.sv */
`include "io_config.svh"

// task scheduling and boot control types
package task_pkg;

  // execution token, bit 0 set means run once
  typedef logic [`IO_WIDTH-1:0] xt_t;

  // one kill request bit per slot
  typedef logic [`NUM_SLOTS-1:0] kill_mask_t;

  // warm-boot pins, packed in data bit order 2..0
  typedef struct packed {
    logic boot;
    logic s1;
    logic s0;
  } boot_ctl_t;

endpackage

/* src/io_capture.sv */
`include "io_config.svh"

module io_capture (
  input  logic                 clk,
  input  logic                 resetq,
  input  logic                 io_rd,
  input  logic                 io_wr,
  input  io_bus_pkg::slot_t    io_slot,
  input  io_bus_pkg::io_word_t io_addr,
  input  io_bus_pkg::io_word_t io_dout,
  output io_bus_pkg::io_req_t  req
);

  // one stage delay, read data for this request comes out next cycle
  always_ff @(posedge clk) begin
    req.slot <= io_slot;
    req.data <= io_dout;
    if (!resetq) begin
      req.rd   <= 1'b0;
      req.wr   <= 1'b0;
      req.addr <= '0;
    end else begin
      req.rd <= io_rd;
      req.wr <= io_wr;
      // idle bus must not hit any register
      if (io_rd | io_wr)
        req.addr <= io_addr;
      else
        req.addr <= '0;
    end
  end

endmodule

/* src/io_mask_bank.sv */
`include "io_config.svh"

module io_mask_bank (
  input  logic                 clk,
  input  logic                 resetq,
  input  io_bus_pkg::io_req_t  req,
  output io_bus_pkg::io_word_t slot_mask
);

  // one pending mask per slot
  io_bus_pkg::io_word_t mask_q [`NUM_SLOTS];

  logic access;
  logic mask_wr;

  assign access  = req.rd | req.wr;
  assign mask_wr = req.wr & req.addr[`ADDR_SLOT_MASK];

  // mask seen by this access is the value before the update
  assign slot_mask = mask_q[req.slot];

  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int s = 0; s < `NUM_SLOTS; s++) begin
        mask_q[s] <= '1;  // open mask
      end
    end else if (access) begin
      // a mask write arms it, anything else uses it up
      if (mask_wr)
        mask_q[req.slot] <= req.data;
      else
        mask_q[req.slot] <= '1;
    end
  end

endmodule

/* src/task_table.sv */
`include "io_config.svh"

module task_table (
  input  logic                   clk,
  input  logic                   resetq,
  input  io_bus_pkg::io_req_t    req,
  output task_pkg::xt_t          xt_raw1,
  output task_pkg::xt_t          xt_raw2,
  output task_pkg::xt_t          xt_raw3,
  output task_pkg::xt_t          xt_fetch,
  output task_pkg::kill_mask_t   kill_slot_rq
);

  // tokens for slots 1..3, slot 0 has none
  task_pkg::xt_t xt_q [1:`NUM_SLOTS-1];

  logic fetch_rd;

  assign fetch_rd = req.rd & req.addr[`ADDR_TASK_FETCH];

  assign xt_raw1 = xt_q[1];
  assign xt_raw2 = xt_q[2];
  assign xt_raw3 = xt_q[3];

  // fetch value for the issuing slot
  always_comb begin
    xt_fetch = '0;  // slot 0 always runs from zero
    for (int k = 1; k < `NUM_SLOTS; k++) begin
      if (req.slot == io_bus_pkg::slot_t'(k))
        xt_fetch = {xt_q[k][`IO_WIDTH-1:1], 1'b0};  // valid tokens are even
    end
  end

  always_ff @(posedge clk) begin
    if (!resetq) begin
      // stops every slot, they do not restart on their own
      for (int k = 1; k < `NUM_SLOTS; k++) begin
        xt_q[k] <= '0;
      end
      kill_slot_rq <= '0;
    end else if (req.wr) begin
      // any slot may schedule any other slot
      for (int k = 1; k < `NUM_SLOTS; k++) begin
        if (req.addr[`ADDR_XT1 + k - 1])
          xt_q[k] <= req.data;
      end
      // kill pulse level, holds until next write
      if (req.addr[`ADDR_TASK_FETCH])
        kill_slot_rq <= req.data[`NUM_SLOTS-1:0];
      else
        kill_slot_rq <= '0;
    end else if (fetch_rd) begin
      for (int k = 1; k < `NUM_SLOTS; k++) begin
        // run-once token, gone after its first fetch
        if (req.slot == io_bus_pkg::slot_t'(k) && xt_q[k][0])
          xt_q[k] <= '0;
      end
    end
  end

endmodule

/* src/port_regs.sv */
`include "io_config.svh"

module port_regs (
  input  logic                  clk,
  input  logic                  resetq,
  input  io_bus_pkg::io_req_t   req,
  input  io_bus_pkg::io_word_t  slot_mask,
  input  io_bus_pkg::io_word_t  pa_in,
  input  logic                  misc_in,
  output io_bus_pkg::io_word_t  pa_out,
  output io_bus_pkg::io_word_t  pa_oe,
  output io_bus_pkg::io_word_t  leds,
  output logic [2:0]            misc_out,
  output task_pkg::boot_ctl_t   warmboot,
  output io_bus_pkg::io_word_t  misc_rd
);

  // set mask bits take new data, cleared bits keep old
  function automatic io_bus_pkg::io_word_t masked_merge(
    input io_bus_pkg::io_word_t old_val,
    input io_bus_pkg::io_word_t new_val,
    input io_bus_pkg::io_word_t mask
  );
    return (new_val & mask) | (old_val & ~mask);
  endfunction

  logic wr_pa_data;
  logic wr_pa_dir;
  logic wr_leds;
  logic wr_misc;
  logic wr_boot;

  // address already zero when idle, so wr alone qualifies
  assign wr_pa_data = req.wr & req.addr[`ADDR_PA_DATA];
  assign wr_pa_dir  = req.wr & req.addr[`ADDR_PA_DIR];
  assign wr_leds    = req.wr & req.addr[`ADDR_LEDS];
  assign wr_misc    = req.wr & req.addr[`ADDR_MISC];
  assign wr_boot    = req.wr & req.addr[`ADDR_WARMBOOT];

  always_ff @(posedge clk) begin
    if (!resetq) begin
      pa_out   <= '0;
      pa_oe    <= '0;   // port comes up as input
      leds     <= '0;
      misc_out <= '0;
      warmboot <= '0;
    end else begin
      // unmasked bits follow the pins, as a port read-modify-write would
      if (wr_pa_data)
        pa_out <= masked_merge(pa_in, req.data, slot_mask);
      if (wr_pa_dir)
        pa_oe <= masked_merge(pa_oe, req.data, slot_mask);  // shared port, per-thread pins
      if (wr_leds)
        leds <= masked_merge(leds, req.data, slot_mask);
      if (wr_misc)
        misc_out <= req.data[2:0];
      // boot, s1, s0 from data bits 2..0
      if (wr_boot)
        warmboot <= task_pkg::boot_ctl_t'(req.data[2:0]);
    end
  end

  // misc readback word
  assign misc_rd = io_bus_pkg::io_word_t'({misc_out, misc_in});

endmodule

/* src/io_read_mux.sv */
`include "io_config.svh"

module io_read_mux (
  input  io_bus_pkg::io_req_t   req,
  input  io_bus_pkg::io_word_t  slot_mask,
  input  io_bus_pkg::io_word_t  pa_in,
  input  io_bus_pkg::io_word_t  pa_oe,
  input  io_bus_pkg::io_word_t  leds,
  input  io_bus_pkg::io_word_t  misc_rd,
  input  task_pkg::xt_t         xt_raw1,
  input  task_pkg::xt_t         xt_raw2,
  input  task_pkg::xt_t         xt_raw3,
  input  task_pkg::xt_t         xt_fetch,
  output io_bus_pkg::io_word_t  io_din
);

  io_bus_pkg::io_word_t rd_or;

  // several address bits may be set, sources just OR
  always_comb begin
    rd_or = '0;
    if (req.addr[`ADDR_PA_DATA])    rd_or = rd_or | pa_in;   // pins, not the out reg
    if (req.addr[`ADDR_PA_DIR])     rd_or = rd_or | pa_oe;
    if (req.addr[`ADDR_LEDS])       rd_or = rd_or | leds;
    if (req.addr[`ADDR_XT1])        rd_or = rd_or | xt_raw1;
    if (req.addr[`ADDR_XT2])        rd_or = rd_or | xt_raw2;
    if (req.addr[`ADDR_XT3])        rd_or = rd_or | xt_raw3;
    if (req.addr[`ADDR_MISC])       rd_or = rd_or | misc_rd;
    if (req.addr[`ADDR_TASK_FETCH]) rd_or = rd_or | xt_fetch;
    // slot id, depends only on who asks
    if (req.addr[`ADDR_SLOT_MASK])
      rd_or = rd_or | io_bus_pkg::io_word_t'(req.slot);
  end

  // cleared mask bits read as zero
  assign io_din = rd_or & slot_mask;

endmodule

/* src/io_hub.sv */
module io_hub (
  input  logic                  clk,
  input  logic                  resetq,
  input  logic                  io_rd,
  input  logic                  io_wr,
  input  io_bus_pkg::slot_t     io_slot,
  input  io_bus_pkg::io_word_t  io_addr,
  input  io_bus_pkg::io_word_t  io_dout,
  output io_bus_pkg::io_word_t  io_din,
  output task_pkg::kill_mask_t  kill_slot_rq,
  input  io_bus_pkg::io_word_t  pa_in,
  output io_bus_pkg::io_word_t  pa_out,
  output io_bus_pkg::io_word_t  pa_oe,
  output io_bus_pkg::io_word_t  leds,
  input  logic                  misc_in,
  output logic [2:0]            misc_out,
  output task_pkg::boot_ctl_t   warmboot
);

  io_bus_pkg::io_req_t  req;        // registered request
  io_bus_pkg::io_word_t slot_mask;  // current slot's mask
  io_bus_pkg::io_word_t misc_rd;
  task_pkg::xt_t        xt_raw1;
  task_pkg::xt_t        xt_raw2;
  task_pkg::xt_t        xt_raw3;
  task_pkg::xt_t        xt_fetch;

  io_capture u_capture (
    .clk     (clk),
    .resetq  (resetq),
    .io_rd   (io_rd),
    .io_wr   (io_wr),
    .io_slot (io_slot),
    .io_addr (io_addr),
    .io_dout (io_dout),
    .req     (req)
  );

  io_mask_bank u_mask_bank (
    .clk       (clk),
    .resetq    (resetq),
    .req       (req),
    .slot_mask (slot_mask)
  );

  task_table u_task_table (
    .clk          (clk),
    .resetq       (resetq),
    .req          (req),
    .xt_raw1      (xt_raw1),
    .xt_raw2      (xt_raw2),
    .xt_raw3      (xt_raw3),
    .xt_fetch     (xt_fetch),
    .kill_slot_rq (kill_slot_rq)
  );

  port_regs u_port_regs (
    .clk       (clk),
    .resetq    (resetq),
    .req       (req),
    .slot_mask (slot_mask),
    .pa_in     (pa_in),
    .misc_in   (misc_in),
    .pa_out    (pa_out),
    .pa_oe     (pa_oe),
    .leds      (leds),
    .misc_out  (misc_out),
    .warmboot  (warmboot),
    .misc_rd   (misc_rd)
  );

  // read data is combinational from the registered request
  io_read_mux u_read_mux (
    .req       (req),
    .slot_mask (slot_mask),
    .pa_in     (pa_in),
    .pa_oe     (pa_oe),
    .leds      (leds),
    .misc_rd   (misc_rd),
    .xt_raw1   (xt_raw1),
    .xt_raw2   (xt_raw2),
    .xt_raw3   (xt_raw3),
    .xt_fetch  (xt_fetch),
    .io_din    (io_din)
  );

endmodule

/* verif/tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk,
  output logic resetq
);

  // period of 4
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    resetq = 1'b0;
    repeat (5) @(posedge clk);  // 5 cycles in reset
    @(negedge clk);             // let go away from the rising edge
    resetq = 1'b1;
  end

endmodule

/* verif/io_hub_tb.sv */
`include "io_config.svh"

module io_hub_tb;

  localparam int RESET_CYCLES    = 5;
  localparam int DIRECTED_CYCLES = 40;  // pa_out, kill, token, boot, pin sweep

  // one line of the vector file
  typedef struct packed {
    logic                 rd;
    logic                 wr;
    io_bus_pkg::slot_t    slot;
    io_bus_pkg::io_word_t addr;
    io_bus_pkg::io_word_t data;
    io_bus_pkg::io_word_t pa_in;
    logic                 misc_in;
    io_bus_pkg::io_word_t exp_din;   // read data seen one cycle later
    io_bus_pkg::io_word_t exp_leds;  // leds before this line's own write
  } vec_t;

  logic                 clk;
  logic                 resetq;
  logic                 io_rd;
  logic                 io_wr;
  io_bus_pkg::slot_t    io_slot;
  io_bus_pkg::io_word_t io_addr;
  io_bus_pkg::io_word_t io_dout;
  io_bus_pkg::io_word_t io_din;
  task_pkg::kill_mask_t kill_slot_rq;
  io_bus_pkg::io_word_t pa_in;
  io_bus_pkg::io_word_t pa_out;
  io_bus_pkg::io_word_t pa_oe;
  io_bus_pkg::io_word_t leds;
  logic                 misc_in;
  logic [2:0]           misc_out;
  task_pkg::boot_ctl_t  warmboot;

  vec_t   vecs[$];
  integer seed        = 32'h9236_bc6c;
  int     cycle_count = 0;
  int     cycle_limit = 1000;  // redone once the vectors are loaded

  tb_clock_gen clock_gen (.clk(clk), .resetq(resetq));

  io_hub DUT (.*);

  task check_word(input string name, input io_bus_pkg::io_word_t expected,
                  input io_bus_pkg::io_word_t actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task check_kill(input string name, input task_pkg::kill_mask_t expected,
                  input task_pkg::kill_mask_t actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task check_boot(input string name, input task_pkg::boot_ctl_t expected,
                  input task_pkg::boot_ctl_t actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %b, actual %b", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  function automatic io_bus_pkg::io_word_t onehot_addr(input int bit_no);
    onehot_addr = '0;
    onehot_addr[bit_no] = 1'b1;
  endfunction

  // drives a request on the falling edge and leaves the pins alone
  task drive_req(input logic rd, input logic wr, input io_bus_pkg::slot_t slot,
                 input io_bus_pkg::io_word_t addr, input io_bus_pkg::io_word_t data);
    @(negedge clk);
    io_rd   = rd;
    io_wr   = wr;
    io_slot = slot;
    io_addr = addr;
    io_dout = data;
  endtask

  task apply_vector(input vec_t v);
    io_rd   = v.rd;
    io_wr   = v.wr;
    io_slot = v.slot;
    io_addr = v.addr;
    io_dout = v.data;
    pa_in   = v.pa_in;
    misc_in = v.misc_in;
  endtask

  task check_vector(input int n);
    check_word($sformatf("vector %0d io_din", n), vecs[n].exp_din, io_din);
    check_word($sformatf("vector %0d leds", n), vecs[n].exp_leds, leds);
  endtask

  task load_vectors();
    int               fd;
    int               code;
    logic [15:0]      f [0:8];
    logic [8*256-1:0] skip_line;
    vec_t             v;
    fd = $fopen("verif/io_hub_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/io_hub_vectors.txt");
      $display("TEST FAILED");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h\n",
                     f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
      if (code == 9) begin
        v.rd       = f[0][0];
        v.wr       = f[1][0];
        v.slot     = f[2][1:0];
        v.addr     = f[3];
        v.data     = f[4];
        v.pa_in    = f[5];
        v.misc_in  = f[6][0];
        v.exp_din  = f[7];
        v.exp_leds = f[8];
        vecs.push_back(v);
      end else if (code > 0) begin
        $display("vector file line %0d is incomplete", vecs.size());
        $display("TEST FAILED");
        $fatal(1);
      end else begin
        code = $fgets(skip_line, fd);  // comment line
      end
    end
    $fclose(fd);
  endtask

  // hang guard
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout, run still going after %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  initial begin
    io_bus_pkg::io_word_t pins;
    io_bus_pkg::io_word_t mask_v;
    io_bus_pkg::io_word_t data_v;
    task_pkg::boot_ctl_t  boot_exp;
    io_rd   = 1'b0;
    io_wr   = 1'b0;
    io_slot = '0;
    io_addr = '0;
    io_dout = '0;
    pa_in   = '0;
    misc_in = 1'b0;
    load_vectors();
    cycle_limit = RESET_CYCLES + vecs.size() + DIRECTED_CYCLES + 20;
    @(posedge resetq);
    @(negedge clk);
    check_word("reset pa_out", '0, pa_out);
    check_word("reset pa_oe", '0, pa_oe);
    check_word("reset leds", '0, leds);
    check_word("reset misc_out", '0, io_bus_pkg::io_word_t'(misc_out));
    check_boot("reset warmboot", '0, warmboot);
    check_kill("reset kill_slot_rq", '0, kill_slot_rq);
    // line i checked while line i+1 goes out
    for (int i = 0; i < vecs.size(); i++) begin
      @(negedge clk);
      if (i > 0)
        check_vector(i - 1);
      apply_vector(vecs[i]);
    end
    @(negedge clk);
    check_vector(vecs.size() - 1);
    // masked pa write takes its cleared bits from the pins
    pins   = 16'h3c3c;
    mask_v = 16'h00ff;
    data_v = 16'h1234;
    pa_in  = pins;
    drive_req(1'b0, 1'b1, 2'd1, onehot_addr(`ADDR_SLOT_MASK), mask_v);
    drive_req(1'b0, 1'b1, 2'd1, onehot_addr(`ADDR_PA_DATA), data_v);
    drive_req(1'b0, 1'b0, 2'd0, '0, '0);
    @(negedge clk);
    check_word("masked pa_out write", 16'h3c34, pa_out);  // low byte data, high byte pins
    drive_req(1'b0, 1'b1, 2'd0, onehot_addr(`ADDR_TASK_FETCH), 16'h0005);
    drive_req(1'b0, 1'b0, 2'd0, '0, '0);
    repeat (2) @(negedge clk);
    check_kill("kill request set", 4'h5, kill_slot_rq);  // held over the idle cycle
    drive_req(1'b0, 1'b1, 2'd0, onehot_addr(`ADDR_MISC), 16'h0006);
    drive_req(1'b0, 1'b0, 2'd0, '0, '0);
    @(negedge clk);
    check_kill("kill request cleared", '0, kill_slot_rq);
    check_word("misc_out write", 16'h0006, io_bus_pkg::io_word_t'(misc_out));
    // slot 0 fetch stays zero with every token loaded
    drive_req(1'b0, 1'b1, 2'd0,
              onehot_addr(`ADDR_XT1) | onehot_addr(`ADDR_XT2) | onehot_addr(`ADDR_XT3),
              16'h2468);
    drive_req(1'b1, 1'b0, 2'd0, onehot_addr(`ADDR_TASK_FETCH), '0);
    @(negedge clk);
    check_word("slot 0 fetch", 16'h0000, io_din);
    drive_req(1'b1, 1'b0, 2'd1, onehot_addr(`ADDR_TASK_FETCH), '0);
    @(negedge clk);
    check_word("slot 1 fetch", 16'h2468, io_din);
    drive_req(1'b0, 1'b1, 2'd3, onehot_addr(`ADDR_WARMBOOT), 16'hfff5);
    // slot 2 mask is all ones here
    for (int i = 0; i < 8; i++) begin
      pins = $random(seed);
      drive_req(1'b1, 1'b0, 2'd2, onehot_addr(`ADDR_PA_DATA), '0);
      pa_in = pins;
      @(negedge clk);
      check_word($sformatf("pin sweep %0d", i), pins & 16'hffff, io_din);
    end
    boot_exp.boot = 1'b1;
    boot_exp.s1   = 1'b0;
    boot_exp.s0   = 1'b1;
    check_boot("warm-boot write", boot_exp, warmboot);
    $display("TEST OK");
    $finish;
  end

endmodule

/* verif/io_hub_vectors.txt */
// rd wr slot addr data pa_in misc_in exp_din exp_leds, all hex
// exp_din shows one cycle later, exp_leds is the value before this line's write
// tokens after reset
1 0 1 0100 0000 0000 0 0000 0000
1 0 1 0200 0000 0000 0 0000 0000
1 0 1 0400 0000 0000 0 0000 0000
1 0 0 4000 0000 0000 0 0000 0000
// led writes through the slot mask
0 1 0 0004 a5c3 0000 0 0000 0000
1 0 0 0004 0000 0000 0 a5c3 a5c3
0 1 2 8000 00ff 0000 0 0002 a5c3
1 0 1 0004 0000 0000 0 a5c3 a5c3
0 1 2 0004 1234 0000 0 00c3 a5c3
1 0 2 0004 0000 0000 0 a534 a534
// pin reads through a mask, direction writes
0 1 1 8000 f0f0 0000 0 0001 a534
1 0 1 0001 0000 9a5c 0 9050 a534
1 0 1 0001 0000 9a5c 0 9a5c a534
0 1 3 0002 0f0f 0000 0 0000 a534
1 0 3 0002 0000 0000 0 0f0f a534
0 1 3 8000 ff00 0000 0 0003 a534
0 1 3 0002 aaaa 0000 0 0f00 a534
1 0 3 0002 0000 0000 0 aa0f a534
// token fetch
0 1 0 0200 1230 0000 0 0000 a534
1 0 2 4000 0000 0000 0 1230 a534
1 0 2 4000 0000 0000 0 1230 a534
0 1 1 0400 4567 0000 0 0000 a534
1 0 3 4000 0000 0000 0 4566 a534
1 0 3 0400 0000 0000 0 0000 a534
1 0 0 0200 0000 0000 0 1230 a534
// slot id, misc readback, unused bits, idle bus, zero mask
1 0 3 8000 0000 0000 0 0003 a534
1 0 2 8000 0000 0000 0 0002 a534
0 1 1 2000 0005 0000 1 0001 a534
1 0 1 2000 0000 0000 0 000a a534
1 0 1 2000 0000 0000 1 000b a534
1 0 0 0006 0000 0000 0 af3f a534
1 0 0 10f8 0000 0000 0 0000 a534
0 0 0 0004 ffff 0000 0 0000 a534
0 1 0 8000 0000 0000 0 0000 a534
1 0 0 0004 0000 0000 0 0000 a534
1 0 0 0004 0000 0000 0 a534 a534

/* list.f */
+incdir+src
src/io_bus_pkg.sv
src/task_pkg.sv
src/io_capture.sv
src/io_mask_bank.sv
src/task_table.sv
src/port_regs.sv
src/io_read_mux.sv
src/io_hub.sv
verif/tb_clock_gen.sv
verif/io_hub_tb.sv

/* Bender.yml */
package:
  name: io_hub

sources:
  - include_dirs:
      - src
    files:
      - src/io_bus_pkg.sv
      - src/task_pkg.sv
      - src/io_capture.sv
      - src/io_mask_bank.sv
      - src/task_table.sv
      - src/port_regs.sv
      - src/io_read_mux.sv
      - src/io_hub.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/tb_clock_gen.sv
      - verif/io_hub_tb.sv
